// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [15:0] word_t;  // ram word, register value and operand
  typedef logic [4:0] reg_idx_t;  // register number

  localparam int NUM_REGS = 32;

  // kept opcodes, numbered as in the full instruction set
  typedef enum logic [7:0] {
    OP_JMP       = 8'd1,   // 24 bit absolute target
    OP_JMP_PLUS  = 8'd5,   // forward by operand instructions
    OP_JMP_MINUS = 8'd7,   // back by operand instructions
    OP_RAM2REG   = 8'd9,   // ram words from operand address into range
    OP_NUM2REG   = 8'd18,
    OP_REG_PLUS  = 8'd19,
    OP_REG_MINUS = 8'd20,
    OP_REG_MUL   = 8'd21,
    OP_REG_DIV   = 8'd22   // unsigned
  } opcode_t;

  typedef enum logic [3:0] {
    ERR_NONE          = 4'd0,
    ERR_WRONG_ADDRESS = 4'd1,
    ERR_DIV_ZERO      = 4'd2,
    ERR_WRONG_REG     = 4'd3,
    ERR_WRONG_OPCODE  = 4'd4
  } error_t;

  // first instruction word; the low byte doubles as jump target bits 23..16
  typedef struct packed {
    logic [7:0] op;
    logic [2:0] count;  // range is base .. base+count
    reg_idx_t   base;
  } instr_t;

endpackage

// ==== rtl/trace_pkg.sv ====
package trace_pkg;

  typedef logic [7:0] trace_char_t;  // one ascii byte

  localparam trace_char_t TRACE_HALT  = "H";  // normal end of program
  localparam trace_char_t TRACE_ERROR = "E";  // followed by the error digit

  // bases for hex and decimal digits
  localparam trace_char_t TRACE_DIGIT_0 = "0";
  localparam trace_char_t TRACE_HEX_A   = "A";

endpackage

// ==== rtl/program_ram.sv ====
module program_ram #(
  parameter int RAM_DEPTH = 128,
  parameter int ADDR_W = $clog2(RAM_DEPTH)
) (
  input  logic clk,
  input  logic we,
  input  logic [ADDR_W-1:0] waddr,
  input  cpu_pkg::word_t wdata,
  input  logic [ADDR_W-1:0] raddr,
  output cpu_pkg::word_t rdata
);
  import cpu_pkg::*;

  word_t mem [RAM_DEPTH];  // program and data words

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;  // load port only
    end
    rdata <= mem[raddr];  // registered read, one cycle late
  end

endmodule

// ==== rtl/trace_fifo.sv ====
module trace_fifo #(
  parameter int TRACE_DEPTH = 16
) (
  input  logic clk,
  input  logic arst_n,
  input  logic push,
  input  trace_pkg::trace_char_t push_char,
  input  logic pop,
  output trace_pkg::trace_char_t pop_char,
  output logic full,
  output logic empty
);
  import trace_pkg::*;

  localparam int PTR_W = (TRACE_DEPTH > 1) ? $clog2(TRACE_DEPTH) : 1;
  localparam int CNT_W = $clog2(TRACE_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  trace_char_t mem [TRACE_DEPTH];
  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;
  logic do_push;
  logic do_pop;

  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(TRACE_DEPTH - 1)) ? '0 : ptr + ptr_t'(1);  // wraps for any depth
  endfunction

  assign full    = count == cnt_t'(TRACE_DEPTH);
  assign empty   = count == '0;
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign pop_char = mem[rd_ptr];  // head visible the cycle after its write

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_char;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      if (do_push && !do_pop) count <= count + cnt_t'(1);
      else if (do_pop && !do_push) count <= count - cnt_t'(1);
    end
  end

endmodule

// ==== rtl/uart_tx.sv ====
module uart_tx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic clk,
  input  logic arst_n,
  input  logic empty,
  input  trace_pkg::trace_char_t char_in,
  output logic pop,
  output logic tx
);
  import trace_pkg::*;

  localparam int DIV_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  typedef logic [DIV_W-1:0] div_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } state_t;

  state_t state;
  div_t div;  // cycles left in the current bit
  logic [2:0] bit_cnt;
  trace_char_t shreg;  // lsb goes out first
  logic bit_end;
  logic ready;

  assign bit_end = div == '0;
  assign ready   = state == ST_IDLE || (state == ST_STOP && bit_end);  // back to back frames
  assign pop     = ready && !empty;

  always_comb begin
    case (state)
      ST_START: tx = 1'b0;
      ST_DATA:  tx = shreg[0];
      default:  tx = 1'b1;  // idle line and stop bit
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= ST_IDLE;
      div     <= '0;
      bit_cnt <= '0;
    end else begin
      div <= bit_end ? div_t'(CLKS_PER_BIT - 1) : div - div_t'(1);
      if (pop) begin
        state <= ST_START;
        div   <= div_t'(CLKS_PER_BIT - 1);
      end else if (state == ST_IDLE) begin
        div <= '0;
      end else if (bit_end) begin
        case (state)
          ST_START: begin
            state   <= ST_DATA;
            bit_cnt <= '0;
          end
          ST_DATA: begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= ST_STOP;
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) shreg <= char_in;
    else if (state == ST_DATA && bit_end) shreg <= shreg >> 1;
  end

endmodule

// ==== rtl/cpu_core.sv ====
module cpu_core #(
  parameter int RAM_DEPTH = 128,
  parameter int ADDR_W = $clog2(RAM_DEPTH)
) (
  input  logic clk,
  input  logic arst_n,
  input  logic run,
  output logic [ADDR_W-1:0] mem_addr,
  input  cpu_pkg::word_t mem_rdata,
  input  logic trace_full,
  output logic trace_push,
  output trace_pkg::trace_char_t trace_char,
  input  cpu_pkg::reg_idx_t dbg_reg_sel,
  output cpu_pkg::word_t dbg_reg_value,
  output logic halted,
  output cpu_pkg::error_t error_code
);
  import cpu_pkg::*;
  import trace_pkg::*;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [ADDR_W:0] pc_t;  // extra bit so a+2 past the end is visible
  typedef logic [23:0] far_t;  // wide enough for any jump target

  localparam far_t DEPTH = far_t'(RAM_DEPTH);

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_FETCH1,
    ST_FETCH2,
    ST_EXECUTE,
    ST_LOAD_WORD,
    ST_EMIT_HI,
    ST_EMIT_LO,
    ST_EMIT_END,
    ST_HALT
  } state_t;

  state_t state;
  pc_t pc;  // address of word 1 of the current instruction
  error_t err_q;
  logic phase;  // second step of load_word and emit_end, 0 elsewhere
  word_t regs [NUM_REGS];

  instr_t instr_q;
  addr_t ld_addr;
  reg_idx_t ld_reg;
  logic [2:0] ld_left;  // words still to load after this one

  far_t a_ext;
  far_t jmp_target;
  far_t step;
  far_t plus_target;
  far_t load_end;
  logic [5:0] reg_end;
  logic reg_over;

  error_t ex_err;
  pc_t ex_pc;
  logic ex_load;
  logic ex_alu;

  function automatic word_t alu(logic [7:0] op, word_t value, word_t operand);
    case (op)
      OP_NUM2REG:   return operand;
      OP_REG_PLUS:  return value + operand;
      OP_REG_MINUS: return value - operand;
      OP_REG_MUL:   return value * operand;  // low 16 bits kept
      OP_REG_DIV:   return value / operand;
      default:      return value;
    endcase
  endfunction

  function automatic trace_char_t hex_digit(logic [3:0] nib);
    if (nib < 4'd10) begin
      return TRACE_DIGIT_0 + trace_char_t'(nib);
    end
    return TRACE_HEX_A + trace_char_t'(nib - 4'd10);
  endfunction

  // operand is on mem_rdata during execute
  assign a_ext       = far_t'(pc);
  assign jmp_target  = {instr_q.count, instr_q.base, mem_rdata};
  assign step        = far_t'({mem_rdata, 1'b0});  // two words per instruction
  assign plus_target = a_ext + step;
  assign load_end    = far_t'(mem_rdata) + far_t'(instr_q.count);
  assign reg_end     = {1'b0, instr_q.base} + {3'b000, instr_q.count};
  assign reg_over    = reg_end >= 6'(NUM_REGS);

  always_comb begin
    ex_err  = ERR_NONE;
    ex_pc   = pc + pc_t'(2);
    ex_load = 1'b0;
    ex_alu  = 1'b0;
    case (instr_q.op)
      OP_JMP: begin
        if (jmp_target[0] || jmp_target >= DEPTH) ex_err = ERR_WRONG_ADDRESS;
        else ex_pc = pc_t'(jmp_target);
      end
      OP_JMP_PLUS: begin
        if (plus_target >= DEPTH) ex_err = ERR_WRONG_ADDRESS;
        else ex_pc = pc_t'(plus_target);
      end
      OP_JMP_MINUS: begin
        if (step > a_ext) ex_err = ERR_WRONG_ADDRESS;
        else ex_pc = pc_t'(a_ext - step);
      end
      OP_RAM2REG: begin
        if (reg_over) ex_err = ERR_WRONG_REG;
        else if (load_end >= DEPTH) ex_err = ERR_WRONG_ADDRESS;
        else ex_load = 1'b1;
      end
      OP_NUM2REG, OP_REG_PLUS, OP_REG_MINUS, OP_REG_MUL: begin
        if (reg_over) ex_err = ERR_WRONG_REG;
        else ex_alu = 1'b1;
      end
      OP_REG_DIV: begin
        if (reg_over) ex_err = ERR_WRONG_REG;
        else if (mem_rdata == '0) ex_err = ERR_DIV_ZERO;
        else ex_alu = 1'b1;
      end
      default: ex_err = ERR_WRONG_OPCODE;
    endcase
  end

  always_comb begin
    case (state)
      ST_FETCH2:    mem_addr = addr_t'(pc + pc_t'(1));  // operand word
      ST_LOAD_WORD: mem_addr = ld_addr;
      default:      mem_addr = addr_t'(pc);
    endcase
  end

  assign trace_push = (state == ST_EMIT_HI || state == ST_EMIT_LO || state == ST_EMIT_END)
                      && !trace_full;

  always_comb begin
    case (state)
      ST_EMIT_HI: trace_char = hex_digit(instr_q.op[7:4]);
      ST_EMIT_LO: trace_char = hex_digit(instr_q.op[3:0]);
      ST_EMIT_END: begin
        if (phase) trace_char = TRACE_DIGIT_0 + trace_char_t'(err_q);
        else if (err_q == ERR_NONE) trace_char = TRACE_HALT;
        else trace_char = TRACE_ERROR;
      end
      default: trace_char = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
      pc    <= '0;
      err_q <= ERR_NONE;
      phase <= 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (state)
        ST_IDLE: if (run) state <= ST_FETCH1;
        ST_FETCH1: begin
          if (a_ext + far_t'(1) >= DEPTH) state <= ST_EMIT_END;  // ran off the end
          else state <= ST_FETCH2;
        end
        ST_FETCH2: state <= ST_EXECUTE;
        ST_EXECUTE: begin
          err_q <= ex_err;
          pc    <= ex_pc;
          if (ex_alu) begin
            for (int i = 0; i < NUM_REGS; i++) begin
              if (6'(i) >= {1'b0, instr_q.base} && 6'(i) <= reg_end) begin
                regs[i] <= alu(instr_q.op, regs[i], mem_rdata);
              end
            end
          end
          state <= ex_load ? ST_LOAD_WORD : ST_EMIT_HI;
        end
        ST_LOAD_WORD: begin
          phase <= !phase;  // read, then write back
          if (phase) begin
            regs[ld_reg] <= mem_rdata;
            if (ld_left == '0) state <= ST_EMIT_HI;
          end
        end
        ST_EMIT_HI: if (!trace_full) state <= ST_EMIT_LO;
        ST_EMIT_LO: begin
          if (!trace_full) state <= (err_q != ERR_NONE) ? ST_EMIT_END : ST_FETCH1;
        end
        ST_EMIT_END: begin
          if (!trace_full) begin
            if (err_q == ERR_NONE || phase) state <= ST_HALT;
            else phase <= 1'b1;  // error digit next
          end
        end
        default: state <= ST_HALT;  // stays until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_FETCH2) begin
      instr_q <= instr_t'(mem_rdata);
    end
    if (state == ST_EXECUTE) begin
      ld_addr <= addr_t'(mem_rdata);  // checked against RAM_DEPTH already
      ld_reg  <= instr_q.base;
      ld_left <= instr_q.count;
    end else if (state == ST_LOAD_WORD && phase) begin
      ld_addr <= ld_addr + addr_t'(1);
      ld_reg  <= ld_reg + reg_idx_t'(1);
      ld_left <= ld_left - 3'd1;
    end
  end

  assign halted        = state == ST_HALT;
  assign error_code    = err_q;
  assign dbg_reg_value = regs[dbg_reg_sel];

endmodule

// ==== rtl/cpu_top.sv ====
module cpu_top #(
  parameter int RAM_DEPTH = 128,
  parameter int ADDR_W = $clog2(RAM_DEPTH),
  parameter int TRACE_DEPTH = 16,
  parameter int CLKS_PER_BIT = 868  // 100 MHz at 115200 baud
) (
  input  logic clk,
  input  logic arst_n,
  input  logic run,
  input  logic load_en,
  input  logic [ADDR_W-1:0] load_addr,
  input  cpu_pkg::word_t load_data,
  input  cpu_pkg::reg_idx_t dbg_reg_sel,
  output cpu_pkg::word_t dbg_reg_value,
  output logic halted,
  output cpu_pkg::error_t error_code,
  output logic tx
);
  import cpu_pkg::*;
  import trace_pkg::*;

  logic [ADDR_W-1:0] mem_addr;
  word_t mem_rdata;
  logic trace_full;
  logic trace_push;
  trace_char_t trace_char;
  logic trace_pop;
  trace_char_t trace_pop_char;
  logic trace_empty;

  program_ram #(
    .RAM_DEPTH(RAM_DEPTH),
    .ADDR_W   (ADDR_W)
  ) u_ram (
    .clk  (clk),
    .we   (load_en),  // write side belongs to the load port
    .waddr(load_addr),
    .wdata(load_data),
    .raddr(mem_addr),
    .rdata(mem_rdata)
  );

  cpu_core #(
    .RAM_DEPTH(RAM_DEPTH),
    .ADDR_W   (ADDR_W)
  ) u_core (
    .clk          (clk),
    .arst_n       (arst_n),
    .run          (run),
    .mem_addr     (mem_addr),
    .mem_rdata    (mem_rdata),
    .trace_full   (trace_full),
    .trace_push   (trace_push),
    .trace_char   (trace_char),
    .dbg_reg_sel  (dbg_reg_sel),
    .dbg_reg_value(dbg_reg_value),
    .halted       (halted),
    .error_code   (error_code)
  );

  trace_fifo #(
    .TRACE_DEPTH(TRACE_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (trace_push),
    .push_char(trace_char),
    .pop      (trace_pop),
    .pop_char (trace_pop_char),
    .full     (trace_full),
    .empty    (trace_empty)
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart (
    .clk    (clk),
    .arst_n (arst_n),
    .empty  (trace_empty),
    .char_in(trace_pop_char),
    .pop    (trace_pop),
    .tx     (tx)
  );

endmodule

// ==== tb/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// fill pattern, every address gets its own word
task automatic clear_image();
  for (int a = 0; a < RAM_DEPTH; a++) begin
    img[a] = 16'hC3A5 ^ word_t'(a * 40503);
  end
endtask

// two-word instruction at addr
task automatic put(int addr, logic [7:0] op, int base, int cnt, word_t opd);
  img[addr]     = {op, 3'(cnt), 5'(base)};
  img[addr + 1] = opd;
endtask

// jump to the last slot, which runs one harmless instruction and falls off the end
task automatic finish_at(int addr);
  put(addr, OP_JMP, 0, 0, word_t'(RAM_DEPTH - 2));
  put(RAM_DEPTH - 2, OP_NUM2REG, 31, 0, 16'h00E1);
endtask

task automatic prog_arith();
  logic [7:0] ops [5];
  clear_image();
  ops = '{OP_NUM2REG, OP_REG_PLUS, OP_REG_MINUS, OP_REG_MUL, OP_REG_DIV};
  put(0, OP_NUM2REG, 0, 7, word_t'($urandom));
  put(2, OP_NUM2REG, 8, 7, word_t'($urandom));
  for (int k = 2; k < 14; k++) begin
    logic [7:0] op;
    word_t opd;
    op  = ops[$urandom % 5];
    opd = word_t'($urandom);
    if (op == OP_REG_DIV) opd = (opd % 16'd300) | 16'd1;  // never zero
    put(2 * k, op, $urandom % 28, $urandom % 4, opd);
  end
  finish_at(28);
endtask

task automatic prog_jumps();
  clear_image();
  put(0, OP_NUM2REG, 1, 0, 16'd1);
  put(2, OP_JMP, 0, 0, 16'd10);  // forward over the block at 4
  put(4, OP_NUM2REG, 2, 0, 16'd2);  // reached later from 12
  put(6, OP_JMP, 0, 0, 16'd16);
  put(8, OP_NUM2REG, 9, 0, 16'd9);  // never runs
  put(10, OP_NUM2REG, 3, 0, 16'd3);
  put(12, OP_JMP_MINUS, 0, 0, 16'd4);  // 12 - 8 = 4
  put(14, OP_NUM2REG, 8, 0, 16'd8);  // never runs
  put(16, OP_JMP_PLUS, 0, 0, 16'd2);  // over 18
  put(18, OP_NUM2REG, 4, 0, 16'd4);  // never runs
  put(20, OP_NUM2REG, 5, 0, 16'd5);
  finish_at(22);
endtask

task automatic prog_ram2reg();
  clear_image();
  for (int a = 64; a < 76; a++) img[a] = word_t'($urandom);
  put(0, OP_RAM2REG, 10, 7, 16'd64);
  put(2, OP_RAM2REG, 20, 3, 16'd70);
  finish_at(4);
endtask

// kind 0 divide by zero, 1 wrong register, 2 odd jump, 3 undefined opcode
task automatic prog_error(int kind);
  clear_image();
  case (kind)
    0: begin
      put(0, OP_NUM2REG, 4, 2, 16'd77);
      put(2, OP_REG_DIV, 4, 2, 16'd0);
    end
    1: begin
      put(0, OP_NUM2REG, 28, 3, 16'd5);
      put(2, OP_REG_PLUS, 30, 3, 16'd1);  // 30 + 3 is past r31
    end
    2: begin
      put(0, OP_NUM2REG, 0, 0, 16'd9);
      put(2, OP_JMP, 0, 0, 16'd7);
    end
    default: begin
      put(0, OP_NUM2REG, 6, 1, 16'd3);
      put(2, 8'hFF, 6, 1, 16'd1);
    end
  endcase
endtask

// every slot runs, so the trace is long enough to fill the FIFO
task automatic prog_long();
  clear_image();
  for (int a = 0; a < RAM_DEPTH - 2; a += 2) begin
    put(a, OP_REG_PLUS, 7, 1, word_t'(a + 1));
  end
  put(RAM_DEPTH - 2, OP_REG_MUL, 7, 0, 16'd3);
endtask

`endif

// ==== tb/tb_cpu_top.sv ====
module tb_cpu_top;
  import cpu_pkg::*;
  import trace_pkg::*;

  localparam int RAM_DEPTH = 128;
  localparam int ADDR_W = $clog2(RAM_DEPTH);
  localparam int CLKS_PER_BIT = 8;
  localparam int WAIT_LIMIT = 200000;

  logic clk;
  logic arst_n;
  logic run;
  logic load_en;
  logic [ADDR_W-1:0] load_addr;
  word_t load_data;
  reg_idx_t dbg_reg_sel;
  word_t dbg_reg_value;
  logic halted;
  error_t error_code;
  logic tx;

  word_t img [RAM_DEPTH];  // program image for the next run
  word_t m_regs [NUM_REGS];  // model registers
  int m_err;
  trace_char_t exp_trace [$];
  trace_char_t rx_chars [$];  // decoded from tx
  logic saw_full;

  cpu_top #(
    .RAM_DEPTH   (RAM_DEPTH),
    .ADDR_W      (ADDR_W),
    .TRACE_DEPTH (4),
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) DUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .run          (run),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .dbg_reg_sel  (dbg_reg_sel),
    .dbg_reg_value(dbg_reg_value),
    .halted       (halted),
    .error_code   (error_code),
    .tx           (tx)
  );

  task automatic stop_run(string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic value_error(string msg);
    stop_run($sformatf("Error at time %0t: %s", $time, msg));
  endtask

  `include "tb_programs.svh"

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // halted holds until reset
  assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
    else value_error("halted dropped before reset");

  // uart receiver, samples each bit in its middle
  initial begin
    logic [7:0] data;
    forever begin
      @(negedge tx);
      repeat (CLKS_PER_BIT / 2) @(posedge clk);
      assert (tx === 1'b0) else value_error("start bit not low at mid-bit");
      for (int b = 0; b < 8; b++) begin
        repeat (CLKS_PER_BIT) @(posedge clk);
        data[b] = tx;
      end
      repeat (CLKS_PER_BIT) @(posedge clk);
      assert (tx === 1'b1) else value_error("stop bit not high");
      rx_chars.push_back(data);
    end
  end

  function automatic trace_char_t to_hex(logic [3:0] nib);
    return (nib < 4'd10) ? trace_char_t'(8'h30 + 8'(nib)) : trace_char_t'(8'h37 + 8'(nib));
  endfunction

  // executes img by the instruction rules and records the expected trace
  task automatic run_model();
    int pc;
    logic [7:0] op;
    int base;
    int cnt;
    int opn;
    word_t opd;
    logic [23:0] tgt;
    bit done;
    for (int i = 0; i < NUM_REGS; i++) m_regs[i] = '0;
    exp_trace.delete();
    m_err = 0;
    pc = 0;
    done = 0;
    for (int steps = 0; steps < 1000 && !done; steps++) begin
      if (pc + 1 >= RAM_DEPTH) begin
        exp_trace.push_back("H");
        done = 1;
      end else begin
        op   = img[pc][15:8];
        cnt  = int'(img[pc][7:5]);
        base = int'(img[pc][4:0]);
        opd  = img[pc + 1];
        opn  = int'(opd);
        tgt  = {img[pc][7:0], opd};
        exp_trace.push_back(to_hex(op[7:4]));
        exp_trace.push_back(to_hex(op[3:0]));
        case (op)
          8'd1: if (tgt[0] || int'(tgt) >= RAM_DEPTH) m_err = 1; else pc = int'(tgt);
          8'd5: if (pc + 2 * opn >= RAM_DEPTH) m_err = 1; else pc = pc + 2 * opn;
          8'd7: if (2 * opn > pc) m_err = 1; else pc = pc - 2 * opn;
          8'd9: begin
            if (base + cnt >= 32) m_err = 3;
            else if (opn + cnt >= RAM_DEPTH) m_err = 1;
            else begin
              for (int i = 0; i <= cnt; i++) m_regs[base + i] = img[opn + i];
              pc += 2;
            end
          end
          8'd18, 8'd19, 8'd20, 8'd21, 8'd22: begin
            if (base + cnt >= 32) m_err = 3;
            else if (op == 8'd22 && opd == 0) m_err = 2;
            else begin
              for (int i = base; i <= base + cnt; i++) begin
                case (op)
                  8'd18: m_regs[i] = opd;
                  8'd19: m_regs[i] = m_regs[i] + opd;
                  8'd20: m_regs[i] = m_regs[i] - opd;
                  8'd21: m_regs[i] = m_regs[i] * opd;
                  default: m_regs[i] = m_regs[i] / opd;
                endcase
              end
              pc += 2;
            end
          end
          default: m_err = 4;
        endcase
        if (m_err != 0) begin
          exp_trace.push_back("E");
          exp_trace.push_back(trace_char_t'(8'h30 + 8'(m_err)));
          done = 1;
        end
      end
    end
    if (!done) stop_run("reference model did not reach an end");
  endtask

  task automatic do_reset();
    arst_n <= 1'b0;
    run <= 1'b0;
    load_en <= 1'b0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    rx_chars.delete();
    assert (halted === 1'b0 && error_code === ERR_NONE && tx === 1'b1)
      else value_error("outputs not at reset values");
  endtask

  task automatic load_image();
    for (int a = 0; a < RAM_DEPTH; a++) begin
      @(posedge clk);
      load_en <= 1'b1;
      load_addr <= ADDR_W'(a);
      load_data <= img[a];
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  // reads one register through the debug port and compares it
  task automatic expect_reg(string name, int idx, word_t want);
    @(posedge clk);
    dbg_reg_sel <= reg_idx_t'(idx);
    @(posedge clk);
    assert (dbg_reg_value === want)
      else value_error($sformatf("%s: r%0d is %h, expected %h", name, idx,
                                 dbg_reg_value, want));
  endtask

  task automatic run_test(string name, error_t want_err);
    int n;
    do_reset();
    load_image();
    run_model();
    assert (m_err == int'(want_err))
      else value_error({name, ": program does not end as intended"});
    saw_full = 1'b0;
    @(posedge clk);
    run <= 1'b1;
    n = 0;
    while (halted !== 1'b1) begin
      @(posedge clk);
      if (DUT.trace_full === 1'b1) saw_full = 1'b1;
      n++;
      if (n > WAIT_LIMIT) stop_run({name, ": timeout waiting for halted"});
    end
    n = 0;
    while (rx_chars.size() < exp_trace.size()) begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT) stop_run({name, ": timeout waiting for the trace"});
    end
    repeat (20 * CLKS_PER_BIT) @(posedge clk);  // room for any extra frame
    assert (rx_chars.size() == exp_trace.size())
      else value_error($sformatf("%s: %0d trace chars, expected %0d", name,
                                 rx_chars.size(), exp_trace.size()));
    for (int i = 0; i < exp_trace.size(); i++) begin
      assert (rx_chars[i] === exp_trace[i])
        else value_error($sformatf("%s: trace char %0d is %h, expected %h", name, i,
                                   rx_chars[i], exp_trace[i]));
    end
    assert (int'(error_code) == m_err)
      else value_error($sformatf("%s: error_code %0d, expected %0d", name, error_code, m_err));
    for (int i = 0; i < NUM_REGS; i++) begin
      expect_reg(name, i, m_regs[i]);
    end
  endtask

  initial begin
    arst_n <= 1'b0;
    run <= 1'b0;
    load_en <= 1'b0;
    load_addr <= '0;
    load_data <= '0;
    dbg_reg_sel <= '0;
    saw_full = 1'b0;
    void'($urandom(56792));

    for (int r = 0; r < 3; r++) begin
      prog_arith();
      run_test("arithmetic", ERR_NONE);
    end
    prog_jumps();
    run_test("jumps", ERR_NONE);
    expect_reg("jumps", 2, 16'd2);  // block at 4, reached back from 12
    expect_reg("jumps", 3, 16'd3);
    expect_reg("jumps", 5, 16'd5);
    expect_reg("jumps", 4, 16'd0);  // skipped blocks
    expect_reg("jumps", 8, 16'd0);
    expect_reg("jumps", 9, 16'd0);
    prog_ram2reg();
    run_test("ram2reg", ERR_NONE);
    for (int i = 0; i < 8; i++) begin
      expect_reg("ram2reg", 10 + i, img[64 + i]);
    end
    for (int i = 0; i < 4; i++) begin
      expect_reg("ram2reg", 20 + i, img[70 + i]);
    end
    prog_error(0);
    run_test("divide by zero", ERR_DIV_ZERO);
    prog_error(1);
    run_test("wrong register", ERR_WRONG_REG);
    prog_error(2);
    run_test("odd jump target", ERR_WRONG_ADDRESS);
    prog_error(3);
    run_test("undefined opcode", ERR_WRONG_OPCODE);
    prog_long();
    run_test("back-pressure", ERR_NONE);
    assert (saw_full === 1'b1) else stop_run("trace FIFO never filled, core was not stalled");
    assert (rx_chars[rx_chars.size() - 1] === TRACE_HALT)
      else value_error("back-pressure: trace does not end with H");

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+tb
rtl/cpu_pkg.sv
rtl/trace_pkg.sv
rtl/program_ram.sv
rtl/trace_fifo.sv
rtl/uart_tx.sv
rtl/cpu_core.sv
rtl/cpu_top.sv
tb/tb_cpu_top.sv

// ==== Makefile ====
TOP = tb_cpu_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
